/* demux_pkg.sv */
package demux_pkg;

   // number of consumer channels behind the demultiplexer
   localparam int NUM_CH = 4;

   // width of one payload word
   localparam int DATA_W = 16;

   // the tag has to name every channel, and a single channel still gets one bit
   localparam int TAG_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

   // channel number as carried on the input stream and inside the store
   typedef logic [TAG_W-1:0] tag_t;

   // one payload word
   typedef logic [DATA_W-1:0] data_t;

   // a beat on the multiplexed input stream
   // the tag selects the channel that the data is delivered on
   typedef struct packed
   {
      tag_t  tag;
      data_t data;
   } in_beat_t;

endpackage

/* store_pkg.sv */
package store_pkg;

   // read grant from the arbiter for the current cycle
   // only one channel is read from the shared RAM per cycle
   typedef struct packed
   {
      logic            valid;
      demux_pkg::tag_t tag;
   } rd_req_t;

   // read response one cycle after the grant
   // the tag travels with the read so the data can be steered
   // into the small FIFO of its channel
   typedef struct packed
   {
      logic             valid;
      demux_pkg::tag_t  tag;
      demux_pkg::data_t data;
   } rd_resp_t;

endpackage

/* chan_tracker.sv */
`timescale 1ns/1ns

module chan_tracker
   #(parameter int ELS = 8,
     localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1)
   (input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  logic                                         in_valid_i,
    input  demux_pkg::in_beat_t                          in_beat_i,
    output logic                                         in_yumi_o,
    input  logic [demux_pkg::NUM_CH-1:0]                 deq_i,
    output logic [demux_pkg::NUM_CH-1:0]                 empty_o,
    output logic                                         wr_en_o,
    output logic [demux_pkg::TAG_W+PTR_W-1:0]            wr_addr_o,
    output demux_pkg::data_t                             wr_data_o,
    output logic [demux_pkg::NUM_CH-1:0][PTR_W-1:0]      rd_ptr_o);

   import demux_pkg::*;

   // one write pointer and one read pointer per channel region of the shared RAM
   logic [NUM_CH-1:0][PTR_W-1:0] wptr_r;
   logic [NUM_CH-1:0][PTR_W-1:0] rptr_r;
   // records whether the last change of the channel was an enqueue
   // equal pointers then mean full, otherwise empty
   logic [NUM_CH-1:0]            last_enq_r;
   logic [NUM_CH-1:0]            full;
   logic [NUM_CH-1:0]            enq;

   // pointers wrap at the end of the channel region, also for ELS not a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(ELS - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   always_comb
   begin
      for (int i = 0; i < NUM_CH; i++)
      begin
         full[i]    = (wptr_r[i] == rptr_r[i]) & last_enq_r[i];
         empty_o[i] = (wptr_r[i] == rptr_r[i]) & ~last_enq_r[i];
      end
   end

   // a beat is taken only when its own channel has room
   // a full channel does not block the others beyond this one cycle
   assign in_yumi_o = in_valid_i & ~full[in_beat_i.tag];
   assign enq       = in_yumi_o ? (NUM_CH'(1) << in_beat_i.tag) : '0;

   // the tag selects the channel region and the write pointer the slot in it
   assign wr_en_o   = in_yumi_o;
   assign wr_addr_o = {in_beat_i.tag, wptr_r[in_beat_i.tag]};
   assign wr_data_o = in_beat_i.data;
   assign rd_ptr_o  = rptr_r;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wptr_r     <= '0;
         rptr_r     <= '0;
         last_enq_r <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_CH; i++)
         begin
            if (enq[i])
               wptr_r[i] <= ptr_next(wptr_r[i]);
            if (deq_i[i])
               rptr_r[i] <= ptr_next(rptr_r[i]);
            // simultaneous enqueue and dequeue leave the occupancy unchanged
            if (enq[i] != deq_i[i])
               last_enq_r[i] <= enq[i];
         end
      end
   end

endmodule

/* read_arbiter.sv */
`timescale 1ns/1ns

module read_arbiter
   #(parameter int ELS = 8,
     parameter int BUFFERING = 3,
     localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1,
     localparam int CNT_W = $clog2(BUFFERING + 1))
   (input  logic                                    clk_i,
    input  logic                                    arst_n_i,
    input  logic [demux_pkg::NUM_CH-1:0]            empty_i,
    input  logic [demux_pkg::NUM_CH-1:0][PTR_W-1:0] rd_ptr_i,
    input  logic [demux_pkg::NUM_CH-1:0]            out_yumi_i,
    output store_pkg::rd_req_t                      rd_req_o,
    output logic [demux_pkg::TAG_W+PTR_W-1:0]       rd_addr_o,
    output logic [demux_pkg::NUM_CH-1:0]            deq_o);

   import demux_pkg::*;

   // free slots in each small output FIFO, as seen from the RAM side
   logic [NUM_CH-1:0][CNT_W-1:0] credit_r;
   logic [NUM_CH-1:0]            reqs;
   logic [NUM_CH-1:0]            grant;
   logic                         found;
   tag_t                         win;
   // channel that has the highest priority in the next arbitration
   tag_t                         prio_r;

   // a channel competes when it has stored words and its small FIFO has room
   always_comb
   begin
      for (int i = 0; i < NUM_CH; i++)
         reqs[i] = ~empty_i[i] & (credit_r[i] != '0);
   end

   // round robin search starting at the priority pointer
   always_comb
   begin
      int idx;
      found = 1'b0;
      win   = prio_r;
      for (int k = 0; k < NUM_CH; k++)
      begin
         idx = (int'(prio_r) + k) % NUM_CH;
         if (!found && reqs[idx])
         begin
            found = 1'b1;
            win   = tag_t'(idx);
         end
      end
   end

   assign grant          = found ? (NUM_CH'(1) << win) : '0;
   assign deq_o          = grant;
   assign rd_req_o.valid = found;
   assign rd_req_o.tag   = win;
   // the winner's oldest word sits at its read pointer inside its region
   assign rd_addr_o      = {win, rd_ptr_i[win]};

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         credit_r <= {NUM_CH{CNT_W'(BUFFERING)}};
         prio_r   <= '0;
      end
      else
      begin
         // a grant takes a credit and a consumer pop gives one back
         for (int i = 0; i < NUM_CH; i++)
         begin
            if (out_yumi_i[i] && !grant[i])
               credit_r[i] <= credit_r[i] + 1'b1;
            else if (grant[i] && !out_yumi_i[i])
               credit_r[i] <= credit_r[i] - 1'b1;
         end
         // the channel after the winner gets first pick next time
         if (found)
            prio_r <= (win == tag_t'(NUM_CH - 1)) ? '0 : win + 1'b1;
      end
   end

endmodule

/* shared_ram.sv */
`timescale 1ns/1ns

module shared_ram
   #(parameter int ELS = 8,
     localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1,
     localparam int ADDR_W = demux_pkg::TAG_W + PTR_W)
   (input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 wr_en_i,
    input  logic [ADDR_W-1:0]    wr_addr_i,
    input  demux_pkg::data_t     wr_data_i,
    input  store_pkg::rd_req_t   rd_req_i,
    input  logic [ADDR_W-1:0]    rd_addr_i,
    output store_pkg::rd_resp_t  rd_resp_o);

   import demux_pkg::*;

   // every channel owns a region of 2**PTR_W words, which is ELS for power of two
   localparam int DEPTH = NUM_CH << PTR_W;

   data_t mem [DEPTH];
   logic  resp_valid_r;
   tag_t  resp_tag_r;
   data_t resp_data_r;

   // one write port and one read port
   // a channel is read only while non-empty, so both never touch the same slot
   always_ff @(posedge clk_i)
   begin
      if (wr_en_i)
         mem[wr_addr_i] <= wr_data_i;
      if (rd_req_i.valid)
         resp_data_r <= mem[rd_addr_i];
      resp_tag_r <= rd_req_i.tag;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         resp_valid_r <= 1'b0;
      else
         resp_valid_r <= rd_req_i.valid;
   end

   assign rd_resp_o.valid = resp_valid_r;
   assign rd_resp_o.tag   = resp_tag_r;
   assign rd_resp_o.data  = resp_data_r;

endmodule

/* out_fifo_bank.sv */
`timescale 1ns/1ns

module out_fifo_bank
   #(parameter int BUFFERING = 3,
     localparam int BPTR_W = $clog2(BUFFERING),
     localparam int CNT_W = $clog2(BUFFERING + 1))
   (input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    input  store_pkg::rd_resp_t                         rd_resp_i,
    output logic [demux_pkg::NUM_CH-1:0]                out_valid_o,
    output demux_pkg::data_t [demux_pkg::NUM_CH-1:0]    out_data_o,
    input  logic [demux_pkg::NUM_CH-1:0]                out_yumi_i);

   import demux_pkg::*;

   // one circular buffer of BUFFERING words per channel
   data_t                         buf_mem [NUM_CH][BUFFERING];
   logic [NUM_CH-1:0][BPTR_W-1:0] wptr_r;
   logic [NUM_CH-1:0][BPTR_W-1:0] rptr_r;
   logic [NUM_CH-1:0][CNT_W-1:0]  count_r;
   logic [NUM_CH-1:0]             push;

   function automatic logic [BPTR_W-1:0] bptr_next(input logic [BPTR_W-1:0] ptr);
      if (ptr == BPTR_W'(BUFFERING - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   // a response lands in the buffer named by its tag
   // credits in the arbiter make sure that buffer has a free slot
   always_comb
   begin
      for (int i = 0; i < NUM_CH; i++)
         push[i] = rd_resp_i.valid && (rd_resp_i.tag == tag_t'(i));
   end

   always_ff @(posedge clk_i)
   begin
      if (rd_resp_i.valid)
         buf_mem[rd_resp_i.tag][wptr_r[rd_resp_i.tag]] <= rd_resp_i.data;
   end

   // the head word is presented for as long as the buffer holds anything
   always_comb
   begin
      for (int i = 0; i < NUM_CH; i++)
      begin
         out_valid_o[i] = (count_r[i] != '0);
         out_data_o[i]  = buf_mem[i][rptr_r[i]];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         count_r <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_CH; i++)
         begin
            if (push[i])
               wptr_r[i] <= bptr_next(wptr_r[i]);
            // yumi is only raised by the consumer while valid is high
            if (out_yumi_i[i])
               rptr_r[i] <= bptr_next(rptr_r[i]);
            if (push[i] && !out_yumi_i[i])
               count_r[i] <= count_r[i] + 1'b1;
            else if (out_yumi_i[i] && !push[i])
               count_r[i] <= count_r[i] - 1'b1;
         end
      end
   end

endmodule

/* tagged_fifo_shared.sv */
`timescale 1ns/1ns

module tagged_fifo_shared
   #(parameter int ELS = 8,
     parameter int BUFFERING = 3)
   (input  logic                                     clk_i,
    input  logic                                     arst_n_i,
    input  logic                                     in_valid_i,
    input  demux_pkg::in_beat_t                      in_beat_i,
    output logic                                     in_yumi_o,
    output logic [demux_pkg::NUM_CH-1:0]             out_valid_o,
    output demux_pkg::data_t [demux_pkg::NUM_CH-1:0] out_data_o,
    input  logic [demux_pkg::NUM_CH-1:0]             out_yumi_i);

   import demux_pkg::*;
   import store_pkg::*;

   localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1;

   // tracker state seen by the arbiter
   logic [NUM_CH-1:0]            empty;
   logic [NUM_CH-1:0][PTR_W-1:0] rd_ptr;
   logic [NUM_CH-1:0]            deq;
   // write port of the shared RAM
   logic                         wr_en;
   logic [TAG_W+PTR_W-1:0]       wr_addr;
   data_t                        wr_data;
   // read port of the shared RAM
   rd_req_t                      rd_req;
   logic [TAG_W+PTR_W-1:0]       rd_addr;
   rd_resp_t                     rd_resp;

   chan_tracker #(.ELS(ELS)) u_tracker
      (.clk_i      (clk_i),
       .arst_n_i   (arst_n_i),
       .in_valid_i (in_valid_i),
       .in_beat_i  (in_beat_i),
       .in_yumi_o  (in_yumi_o),
       .deq_i      (deq),
       .empty_o    (empty),
       .wr_en_o    (wr_en),
       .wr_addr_o  (wr_addr),
       .wr_data_o  (wr_data),
       .rd_ptr_o   (rd_ptr));

   // the consumer pops return credits directly to the arbiter
   read_arbiter #(.ELS(ELS), .BUFFERING(BUFFERING)) u_arbiter
      (.clk_i      (clk_i),
       .arst_n_i   (arst_n_i),
       .empty_i    (empty),
       .rd_ptr_i   (rd_ptr),
       .out_yumi_i (out_yumi_i),
       .rd_req_o   (rd_req),
       .rd_addr_o  (rd_addr),
       .deq_o      (deq));

   shared_ram #(.ELS(ELS)) u_ram
      (.clk_i      (clk_i),
       .arst_n_i   (arst_n_i),
       .wr_en_i    (wr_en),
       .wr_addr_i  (wr_addr),
       .wr_data_i  (wr_data),
       .rd_req_i   (rd_req),
       .rd_addr_i  (rd_addr),
       .rd_resp_o  (rd_resp));

   out_fifo_bank #(.BUFFERING(BUFFERING)) u_out
      (.clk_i       (clk_i),
       .arst_n_i    (arst_n_i),
       .rd_resp_i   (rd_resp),
       .out_valid_o (out_valid_o),
       .out_data_o  (out_data_o),
       .out_yumi_i  (out_yumi_i));

endmodule

/* tb_tagged_fifo_shared.sv */
`timescale 1ns/1ns

module tb_tagged_fifo_shared;

   import demux_pkg::*;

   localparam int ELS_TB = 8;
   localparam int BUF_TB = 3;
   // beats of the stall phase come first, then randomly tagged beats
   localparam int STALL_LEN = 17;
   localparam int TABLE_LEN = STALL_LEN + 48;
   // cycles a stalled beat is offered before it counts as refused
   localparam int STALL_WAIT = 10;
   localparam int DRAIN_CYCLES = 500;
   localparam int WATCHDOG_CYCLES = TABLE_LEN * 40 + DRAIN_CYCLES;

   // one table row holds the consumer mode, the channel tag and the payload
   typedef struct packed
   {
      logic  stall;
      tag_t  tag;
      data_t data;
   } stim_t;

   logic                     clk;
   logic                     arst_n;
   logic                     in_valid;
   in_beat_t                 in_beat;
   logic                     in_yumi;
   logic [NUM_CH-1:0]        out_valid;
   data_t [NUM_CH-1:0]       out_data;
   logic [NUM_CH-1:0]        out_yumi;

   stim_t stim_tab [TABLE_LEN];
   // words accepted but not yet popped are kept in acceptance order per channel
   data_t ref_q [NUM_CH][$];
   int    acc_cnt [NUM_CH];
   int    pop_cnt [NUM_CH];
   logic  [NUM_CH-1:0] hold_valid;
   data_t hold_data [NUM_CH];
   data_t exp_word;
   logic  stall_mode;
   int    errors;
   int    delivered;

   tagged_fifo_shared #(.ELS(ELS_TB), .BUFFERING(BUF_TB)) u_dut
      (.clk_i       (clk),
       .arst_n_i    (arst_n),
       .in_valid_i  (in_valid),
       .in_beat_i   (in_beat),
       .in_yumi_o   (in_yumi),
       .out_valid_o (out_valid),
       .out_data_o  (out_data),
       .out_yumi_i  (out_yumi));

   always #5 clk = ~clk;

   // stall rows fill channel 0 past its capacity, then try channels 1 and 2
   task automatic build_table();
      for (int i = 0; i < TABLE_LEN; i++)
      begin
         stim_tab[i].stall = (i < STALL_LEN);
         if (i < 12 || i == 15)
            stim_tab[i].tag = tag_t'(0);
         else if (i < 15)
            stim_tab[i].tag = tag_t'(1);
         else if (i == 16)
            stim_tab[i].tag = tag_t'(2);
         else
            stim_tab[i].tag = tag_t'($urandom % NUM_CH);
         // the low byte is the row index so every word is unique
         stim_tab[i].data = data_t'(($urandom & 32'hFF00) | i);
      end
   endtask

   function automatic int outstanding();
      int sum;
      sum = 0;
      for (int c = 0; c < NUM_CH; c++)
         sum += ref_q[c].size();
      return sum;
   endfunction

   task automatic check_idle(input string when);
      assert (out_valid == '0)
      else
      begin
         errors++;
         $display("FAILED at %0t: out_valid is %b %s, expected all low", $time, out_valid, when);
      end
   endtask

   // this task offers one beat and starts and ends 1 ns after a rising edge
   task automatic apply_beat(input stim_t s);
      int   held;
      int   waited;
      logic expect_take;
      logic taken;
      logic done;
      stall_mode = s.stall;
      in_valid = 1'b1;
      in_beat.tag = s.tag;
      in_beat.data = s.data;
      // with no pops a channel holds ELS words in RAM and BUFFERING in its FIFO
      held = acc_cnt[s.tag] - pop_cnt[s.tag];
      expect_take = !(s.stall && held >= ELS_TB + BUF_TB);
      taken = 1'b0;
      done = 1'b0;
      waited = 0;
      while (!done)
      begin
         @(negedge clk);
         if (in_yumi)
         begin
            taken = 1'b1;
            done = 1'b1;
         end
         else if (s.stall && waited == STALL_WAIT - 1)
            done = 1'b1;
         waited++;
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
      if (taken)
      begin
         ref_q[s.tag].push_back(s.data);
         acc_cnt[s.tag]++;
      end
      assert (taken == expect_take)
      else
      begin
         errors++;
         $display("FAILED at %0t: channel %0d beat %h was %s with %0d words held", $time,
                  s.tag, s.data, taken ? "accepted" : "refused", held);
      end
   endtask

   // the consumer pops at random unless the stall phase is active
   // the mode is taken at the edge so a change made 1 ns later counts from the next cycle
   always @(posedge clk)
   begin
      logic pops_on;
      pops_on = !stall_mode;
      #1;
      for (int c = 0; c < NUM_CH; c++)
         out_yumi[c] = pops_on && out_valid[c] && (($urandom % 2) == 1);
   end

   // the outputs are checked mid-cycle where they are settled
   always @(negedge clk)
   begin
      for (int c = 0; c < NUM_CH; c++)
      begin
         // a word that was not taken must stay put
         if (hold_valid[c])
         begin
            assert (out_valid[c] && out_data[c] == hold_data[c])
            else
            begin
               errors++;
               $display("FAILED at %0t: channel %0d head changed to %h from %h while stalled",
                        $time, c, out_data[c], hold_data[c]);
            end
         end
         if (out_valid[c] && out_yumi[c])
         begin
            assert (ref_q[c].size() > 0)
            else
            begin
               errors++;
               $display("channel %0d delivered a word at %0t with none outstanding", c, $time);
            end
            if (ref_q[c].size() > 0)
            begin
               exp_word = ref_q[c].pop_front();
               delivered++;
               pop_cnt[c]++;
               assert (out_data[c] == exp_word)
               else
               begin
                  errors++;
                  $display("FAILED at %0t: channel %0d gave %h, expected %h", $time, c,
                           out_data[c], exp_word);
               end
            end
         end
         hold_valid[c] = out_valid[c] && !out_yumi[c];
         hold_data[c] = out_data[c];
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      clk = 1'b0;
      arst_n = 1'b0;
      in_valid = 1'b0;
      in_beat = '0;
      out_yumi = '0;
      stall_mode = 1'b1;
      hold_valid = '0;
      errors = 0;
      delivered = 0;
      for (int c = 0; c < NUM_CH; c++)
      begin
         acc_cnt[c] = 0;
         pop_cnt[c] = 0;
      end
      void'($urandom(84724));
      build_table();
      repeat (8)
      begin
         @(negedge clk);
         check_idle("during reset");
      end
      @(posedge clk);
      #1 arst_n = 1'b1;
      @(negedge clk);
      check_idle("right after reset");
      @(posedge clk);
      #1;
      for (int i = 0; i < TABLE_LEN; i++)
         apply_beat(stim_tab[i]);
      // drain with random back-pressure until every accepted word came out
      stall_mode = 1'b0;
      while (outstanding() != 0)
         @(negedge clk);
      @(posedge clk);
      #1;
      check_idle("after draining");
      $display("closing count: %0d errors, %0d words delivered, %0d words outstanding",
               errors, delivered, outstanding());
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* files.f */
demux_pkg.sv
store_pkg.sv
chan_tracker.sv
read_arbiter.sv
shared_ram.sv
out_fifo_bank.sv
tagged_fifo_shared.sv
tb_tagged_fifo_shared.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module tb_tagged_fifo_shared \
   && ./obj_dir/Vtb_tagged_fifo_shared > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "ALL TESTS PASSED" sim.log \
   && echo "simulation passed" && exit 0 \
   || echo "simulation failed" && exit 1
